//--- design/scurvePkg.sv
`default_nettype none

package scurvePkg;

  ////////////////////
  // Widths that carry a meaning
  typedef logic [15:0]  dataWordT;   // USB stream word and count word
  typedef logic [9:0]   dacCodeT;    // Threshold DAC code
  typedef logic [5:0]   chanT;       // Channel index, 64 channels
  typedef logic [63:0]  chanMaskT;   // CTest injection, one bit per channel
  typedef logic [191:0] discriMaskT; // Three discriminator enables per channel

  ////////////////////
  // Stream word codes
  localparam dataWordT   HeaderWord    = 16'h5343; // ASCII "SC"
  localparam dataWordT   TailWord      = 16'hFF45;
  localparam logic [7:0] SingleChanTag = 8'h43;    // "C"
  localparam logic [7:0] AllChanTag    = 8'h63;    // "c"
  localparam logic [3:0] DacTag        = 4'hD;

  ////////////////////
  // Scan controller states
  typedef enum logic [4:0] {
    Idle,
    HeaderOut,
    ChanSetup,  ChanOut,    // Channel word and mask setup
    DacSetup,   DacOut,     // DAC word and code setup
    LoadConfig, WaitBusy,   WaitConfig, Settle,
    StartCount, WaitCount,
    DrainCheck, DrainGet,   DrainOut,   // Count words to USB
    NextDac,    NextChan,
    TailOut,    TailWait,
    DoneSet,    DoneHold
  } ctrlStateT;

endpackage

`default_nettype wire

//--- design/triggerCounter.sv
`default_nettype none

module triggerCounter import scurvePkg::*; #(
  parameter logic [15:0] CountWindow = 16'd10000
) (
  input  logic     Clk,
  input  logic     reset_n,
  input  logic     countStart,
  input  logic     trigger,
  output logic     fifoWrite,
  output dataWordT fifoData,
  output logic     countDone
);

  logic        windowActive;
  dataWordT    eventCount;
  logic [15:0] sampleCount;  // Trigger samples taken so far

  dataWordT    baseCount;
  logic [15:0] baseSamples;
  dataWordT    nextCount;
  logic        lastSample;

  ////////////////////
  // Next sample
  // The start edge is already the first sample of the window
  always_comb begin
    baseCount   = countStart ? '0 : eventCount;
    baseSamples = countStart ? '0 : sampleCount;
    if (trigger && (baseCount != 16'hFFFF)) begin
      nextCount = baseCount + 16'd1;
    end else begin
      nextCount = baseCount;  // Saturate at full scale
    end
    lastSample = (baseSamples == CountWindow - 16'd1);
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      windowActive <= 1'b0;
      eventCount   <= '0;
      sampleCount  <= '0;
      fifoWrite    <= 1'b0;
      countDone    <= 1'b0;
    end else begin
      fifoWrite <= 1'b0;
      countDone <= fifoWrite;  // One cycle after the word went in
      if (countStart || windowActive) begin
        eventCount  <= nextCount;
        sampleCount <= baseSamples + 16'd1;
        if (lastSample) begin
          windowActive <= 1'b0;
          fifoWrite    <= 1'b1;
        end else begin
          windowActive <= 1'b1;
        end
      end
    end
  end

  // Count stays put until the next window is armed
  assign fifoData = eventCount;

endmodule

`default_nettype wire

//--- design/countFifo.sv
`default_nettype none

module countFifo import scurvePkg::*; #(
  parameter int FifoDepth = 4
) (
  input  logic     Clk,
  input  logic     reset_n,
  input  logic     fifoWrite,
  input  dataWordT fifoWriteData,
  input  logic     fifoRead,
  output dataWordT fifoReadData,
  output logic     fifoEmpty
);

  localparam int PtrWidth = $clog2(FifoDepth);

  typedef logic [PtrWidth-1:0] ptrT;
  typedef logic [PtrWidth:0]   fillT;

  dataWordT mem [FifoDepth];
  ptrT      wrPtr;
  ptrT      rdPtr;
  fillT     fillCount;
  logic     fifoFull;
  logic     doWrite;
  logic     doRead;

  assign fifoFull  = (fillCount == fillT'(FifoDepth));
  assign fifoEmpty = (fillCount == '0);
  assign doWrite   = fifoWrite && !fifoFull;
  assign doRead    = fifoRead && !fifoEmpty;

  assign fifoReadData = mem[rdPtr];  // Oldest word, first word fall-through

  always_ff @(posedge Clk) begin
    if (doWrite) begin
      mem[wrPtr] <= fifoWriteData;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fillCount <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + ptrT'(1);  // Wraps, depth is a power of two
      end
      if (doRead) begin
        rdPtr <= rdPtr + ptrT'(1);
      end
      if (doWrite && !doRead) begin
        fillCount <= fillCount + fillT'(1);
      end else if (doRead && !doWrite) begin
        fillCount <= fillCount - fillT'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/scurveControl.sv
`default_nettype none

module scurveControl import scurvePkg::*; #(
  parameter dacCodeT     LastDac      = 10'd1023,
  parameter logic [15:0] SettleCycles = 16'd40000
) (
  input  logic       Clk,
  input  logic       reset_n,
  input  logic       testStart,
  input  logic       singleMode,
  input  chanT       singleChan,
  input  logic       ctestInject,
  input  logic       configDone,
  input  logic       countDone,
  input  logic       fifoEmpty,
  input  dataWordT   fifoData,
  input  logic       usbFull,
  input  logic       transmitDone,
  output logic       countStart,
  output logic       fifoRead,
  output chanMaskT   ctestChan,
  output dacCodeT    dacCode,
  output discriMaskT discriMask,
  output logic       scLoad,
  output logic       forceRaz,
  output dataWordT   usbData,
  output logic       usbWrite,
  output logic       testDone
);

  localparam discriMaskT ChanDiscriBits = discriMaskT'(3'b111);
  localparam chanMaskT   ChanCtestBit   = chanMaskT'(1);

  ctrlStateT   state;
  chanT        testChan;    // Channel under test
  logic        scanSingle;  // Mode taken at start of scan
  dacCodeT     dacStep;
  logic [15:0] settleCnt;
  logic [3:0]  tailCnt;
  logic [7:0]  maskShift;

  assign maskShift = {2'b00, testChan} * 8'd3;  // Three bits per channel

  // Chip shifts the DAC code in LSB first
  function automatic dacCodeT reverseBits(input dacCodeT code);
    dacCodeT flipped;
    for (int i = 0; i < $bits(dacCodeT); i++) begin
      flipped[i] = code[$bits(dacCodeT) - 1 - i];
    end
    return flipped;
  endfunction

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= Idle;
      testChan   <= '0;
      scanSingle <= 1'b0;
      dacStep    <= '0;
      settleCnt  <= '0;
      tailCnt    <= '0;
      countStart <= 1'b0;
      fifoRead   <= 1'b0;
      ctestChan  <= '0;
      dacCode    <= '0;
      discriMask <= '1;  // All discriminators enabled
      scLoad     <= 1'b0;
      forceRaz   <= 1'b0;
      usbData    <= '0;
      usbWrite   <= 1'b0;
      testDone   <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          testDone <= 1'b0;
          if (testStart) begin
            usbData    <= HeaderWord;
            scanSingle <= singleMode;
            testChan   <= singleMode ? singleChan : '0;
            dacStep    <= '0;
            state      <= HeaderOut;
          end
        end
        HeaderOut: begin
          usbWrite <= 1'b1;
          state    <= ChanSetup;
        end

        ////////////////////
        // Per channel
        ChanSetup: begin
          usbWrite   <= 1'b0;
          usbData    <= {(scanSingle ? SingleChanTag : AllChanTag), 2'b00, testChan};
          discriMask <= ChanDiscriBits << maskShift;
          ctestChan  <= ctestInject ? (ChanCtestBit << testChan) : '0;
          state      <= ChanOut;
        end
        ChanOut: begin
          usbWrite <= 1'b1;
          state    <= DacSetup;
        end

        ////////////////////
        // Per DAC step
        DacSetup: begin
          usbWrite <= 1'b0;
          dacCode  <= reverseBits(dacStep);
          usbData  <= {DacTag, 2'b00, dacStep};  // Stream keeps natural order
          state    <= DacOut;
        end
        DacOut: begin
          usbWrite <= 1'b1;
          state    <= LoadConfig;
        end
        LoadConfig: begin
          usbWrite <= 1'b0;
          scLoad   <= 1'b1;
          forceRaz <= 1'b1;  // Hold discriminators in reset while loading
          state    <= WaitBusy;
        end
        WaitBusy: begin
          scLoad <= 1'b0;
          if (configDone) begin
            state <= WaitConfig;
          end
        end
        WaitConfig: begin
          if (!configDone) begin
            settleCnt <= '0;
            state     <= Settle;
          end
        end
        Settle: begin
          if (settleCnt == SettleCycles - 16'd1) begin
            forceRaz <= 1'b0;
            state    <= StartCount;
          end else begin
            settleCnt <= settleCnt + 16'd1;
          end
        end
        StartCount: begin
          countStart <= 1'b1;
          state      <= WaitCount;
        end
        WaitCount: begin
          countStart <= 1'b0;
          if (countDone) begin
            state <= DrainCheck;
          end
        end

        ////////////////////
        // Count words to USB
        DrainCheck: begin
          usbWrite <= 1'b0;
          if (fifoEmpty) begin
            state <= NextDac;
          end else begin
            fifoRead <= 1'b1;
            state    <= DrainGet;
          end
        end
        DrainGet: begin
          fifoRead <= 1'b0;
          usbData  <= fifoData;  // Word at head, popped on this edge
          state    <= DrainOut;
        end
        DrainOut: begin
          if (!usbFull) begin  // Hold the word while USB FIFO is full
            usbWrite <= 1'b1;
            state    <= DrainCheck;
          end
        end
        NextDac: begin
          if (dacStep == LastDac) begin
            dacStep <= '0;
            state   <= NextChan;
          end else begin
            dacStep <= dacStep + 10'd1;
            state   <= DacSetup;
          end
        end
        NextChan: begin
          if (scanSingle || (testChan == 6'd63)) begin
            usbData <= TailWord;
            state   <= TailOut;
          end else begin
            testChan <= testChan + 6'd1;
            state    <= ChanSetup;
          end
        end

        ////////////////////
        // Tail and completion
        TailOut: begin
          usbWrite <= 1'b1;
          tailCnt  <= '0;
          state    <= TailWait;
        end
        TailWait: begin
          usbWrite <= 1'b0;
          if (tailCnt == 4'd15) begin
            state <= DoneSet;
          end else begin
            tailCnt <= tailCnt + 4'd1;
          end
        end
        DoneSet: begin
          testDone <= 1'b1;
          state    <= DoneHold;
        end
        DoneHold: begin
          if (transmitDone) begin  // Host has the data
            testDone <= 1'b0;
            state    <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/scurveTop.sv
`default_nettype none

module scurveTop import scurvePkg::*; #(
  parameter dacCodeT     LastDac      = 10'd1023,
  parameter logic [15:0] SettleCycles = 16'd40000,
  parameter logic [15:0] CountWindow  = 16'd10000,
  parameter int          FifoDepth    = 4
) (
  input  logic       Clk,
  input  logic       reset_n,
  // Host control
  input  logic       testStart,
  input  logic       singleMode,
  input  chanT       singleChan,
  input  logic       ctestInject,
  input  logic       transmitDone,
  output logic       testDone,
  // Chip side
  input  logic       configDone,
  input  logic       trigger,
  output chanMaskT   ctestChan,
  output dacCodeT    dacCode,
  output discriMaskT discriMask,
  output logic       scLoad,
  output logic       forceRaz,
  // USB FIFO write port
  input  logic       usbFull,
  output dataWordT   usbData,
  output logic       usbWrite
);

  logic     countStart;
  logic     countDone;
  logic     fifoWrite;
  dataWordT countWord;   // Counter into FIFO
  logic     fifoRead;
  logic     fifoEmpty;
  dataWordT fifoData;    // FIFO head to controller

  ////////////////////
  // Producer
  triggerCounter #(
    .CountWindow (CountWindow)
  ) counter0 (
    .Clk        (Clk),
    .reset_n    (reset_n),
    .countStart (countStart),
    .trigger    (trigger),
    .fifoWrite  (fifoWrite),
    .fifoData   (countWord),
    .countDone  (countDone)
  );

  countFifo #(
    .FifoDepth (FifoDepth)
  ) fifo0 (
    .Clk           (Clk),
    .reset_n       (reset_n),
    .fifoWrite     (fifoWrite),
    .fifoWriteData (countWord),
    .fifoRead      (fifoRead),
    .fifoReadData  (fifoData),
    .fifoEmpty     (fifoEmpty)
  );

  ////////////////////
  // Consumer
  scurveControl #(
    .LastDac      (LastDac),
    .SettleCycles (SettleCycles)
  ) control0 (
    .Clk          (Clk),
    .reset_n      (reset_n),
    .testStart    (testStart),
    .singleMode   (singleMode),
    .singleChan   (singleChan),
    .ctestInject  (ctestInject),
    .configDone   (configDone),
    .countDone    (countDone),
    .fifoEmpty    (fifoEmpty),
    .fifoData     (fifoData),
    .usbFull      (usbFull),
    .transmitDone (transmitDone),
    .countStart   (countStart),
    .fifoRead     (fifoRead),
    .ctestChan    (ctestChan),
    .dacCode      (dacCode),
    .discriMask   (discriMask),
    .scLoad       (scLoad),
    .forceRaz     (forceRaz),
    .usbData      (usbData),
    .usbWrite     (usbWrite),
    .testDone     (testDone)
  );

endmodule

`default_nettype wire

//--- tests/scurveTop_properties.sv
`default_nettype none

module scurveTopProperties (
  input logic Clk,
  input logic reset_n,
  input logic scLoad,
  input logic usbWrite,
  input logic usbFull,
  input logic fifoRead,
  input logic testDone,
  input logic transmitDone
);

  logic forwarding;  // Count word held for the USB FIFO

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      forwarding <= 1'b0;
    end else if (fifoRead) begin
      forwarding <= 1'b1;
    end else if (!usbFull) begin
      forwarding <= 1'b0;
    end
  end

  holdOnFull: assert property (@(posedge Clk) disable iff (!reset_n)
    forwarding && usbFull |=> !usbWrite)
    else $error("Count word written while the USB FIFO was full");

  scLoadPulse: assert property (@(posedge Clk) disable iff (!reset_n) scLoad |=> !scLoad)
    else $error("scLoad held longer than one cycle");

  usbWritePulse: assert property (@(posedge Clk) disable iff (!reset_n)
    usbWrite |=> !usbWrite)
    else $error("usbWrite held longer than one cycle");

  doneHeld: assert property (@(posedge Clk) disable iff (!reset_n)
    testDone && !transmitDone |=> testDone)
    else $error("testDone dropped before transmitDone");

endmodule

bind scurveTop scurveTopProperties props0 (
  .Clk          (Clk),
  .reset_n      (reset_n),
  .scLoad       (scLoad),
  .usbWrite     (usbWrite),
  .usbFull      (usbFull),
  .fifoRead     (fifoRead),
  .testDone     (testDone),
  .transmitDone (transmitDone)
);

`default_nettype wire

//--- tests/scurveTb.sv
`default_nettype none

module scurveTb import scurvePkg::*; ();

  localparam dacCodeT     TbLastDac      = 10'd3;
  localparam logic [15:0] TbSettleCycles = 16'd5;
  localparam logic [15:0] TbCountWindow  = 16'd12;
  localparam int          TbFifoDepth    = 4;
  localparam int          RunTimeout     = 60000;  // Cycles per wait loop

  // Stream codes of the scan format
  localparam dataWordT   ExpHeader    = 16'h5343;
  localparam dataWordT   ExpTail      = 16'hFF45;
  localparam logic [7:0] ExpSingleTag = 8'h43;
  localparam logic [7:0] ExpAllTag    = 8'h63;
  localparam logic [3:0] ExpDacTag    = 4'hD;

  typedef enum logic [1:0] {PlainWord, ChanWord, DacWord, CountWord} wordKindT;

  logic Clk;
  logic reset_n, testStart, singleMode, ctestInject;
  chanT singleChan;
  logic configDone = 1'b0;
  logic trigger = 1'b0;
  logic usbFull = 1'b0;
  logic transmitDone = 1'b0;
  chanMaskT ctestChan;
  dacCodeT dacCode;
  discriMaskT discriMask;
  logic scLoad, forceRaz, usbWrite, testDone;
  dataWordT usbData;

  int errors = 0;
  int checks = 0;
  logic timedOut = 1'b0;
  dataWordT expWords[$];
  wordKindT expKinds[$];
  dataWordT modelCounts[$];  // Trigger counts of closed windows
  int windowLeft = 0;
  dataWordT trigCount = '0;
  logic prevRaz = 1'b0;
  chanT curChan = '0;
  dacCodeT curDac = '0;
  int cfgLeft = 0;
  int ackWait = 0;

  scurveTop #(
    .LastDac      (TbLastDac),
    .SettleCycles (TbSettleCycles),
    .CountWindow  (TbCountWindow),
    .FifoDepth    (TbFifoDepth)
  ) dut0 (
    .Clk(Clk), .reset_n(reset_n), .testStart(testStart), .singleMode(singleMode),
    .singleChan(singleChan), .ctestInject(ctestInject), .transmitDone(transmitDone),
    .testDone(testDone), .configDone(configDone), .trigger(trigger),
    .ctestChan(ctestChan), .dacCode(dacCode), .discriMask(discriMask),
    .scLoad(scLoad), .forceRaz(forceRaz), .usbFull(usbFull), .usbData(usbData),
    .usbWrite(usbWrite)
  );

  initial begin
    Clk = 1'b0;
    forever #20 Clk = ~Clk;
  end

  ////////////////////
  // Chip and host responders
  always @(posedge Clk) begin
    trigger <= ($urandom_range(0, 1) == 1);
    usbFull <= ($urandom_range(0, 99) < 30);  // Full about 30 percent of cycles
  end

  always @(posedge Clk) begin
    if (cfgLeft > 0) begin
      cfgLeft = cfgLeft - 1;
    end else if (scLoad) begin
      cfgLeft = int'($urandom_range(1, 6));  // Configuration busy time
    end
    configDone <= (cfgLeft > 0);
  end

  always @(posedge Clk) begin
    if (!testDone) begin
      ackWait = int'($urandom_range(2, 6));
      transmitDone <= 1'b0;
    end else if (ackWait > 0) begin
      ackWait = ackWait - 1;
    end else begin
      transmitDone <= 1'b1;
    end
  end

  ////////////////////
  // Stream model and checks
  task automatic buildStream(input logic single, input chanT chan);
    int firstChan;
    int lastChan;
    firstChan = single ? int'(chan) : 0;
    lastChan  = single ? int'(chan) : 63;
    expWords.push_back(ExpHeader);
    expKinds.push_back(PlainWord);
    for (int c = firstChan; c <= lastChan; c++) begin
      expWords.push_back({(single ? ExpSingleTag : ExpAllTag), 2'b00, chanT'(c)});
      expKinds.push_back(ChanWord);
      for (int d = 0; d <= int'(TbLastDac); d++) begin
        expWords.push_back({ExpDacTag, 2'b00, dacCodeT'(d)});
        expKinds.push_back(DacWord);
        expWords.push_back(16'h0000);  // Taken from the trigger model
        expKinds.push_back(CountWord);
      end
    end
    expWords.push_back(ExpTail);
    expKinds.push_back(PlainWord);
  endtask

  task automatic checkWord(input dataWordT word);
    dataWordT expected;
    wordKindT kind;
    if (expWords.size() == 0) begin
      errors++;
      $display("Unexpected USB word %h written at %0t", word, $time);
    end else begin
      expected = expWords.pop_front();
      kind     = expKinds.pop_front();
      if (kind == CountWord && modelCounts.size() == 0) begin
        errors++;
        $display("Count word written at %0t before its trigger window closed", $time);
      end else begin
        if (kind == CountWord) begin
          expected = modelCounts.pop_front();
        end
        checks++;
        if (word !== expected) begin
          errors++;
          $display("mismatch at %0t: USB word %h, expected %h", $time, word, expected);
        end
        if (kind == ChanWord) begin
          curChan = expected[5:0];
        end
        if (kind == DacWord) begin
          curDac = expected[9:0];
        end
      end
    end
  endtask

  task automatic checkParams();
    dacCodeT    revDac;
    discriMaskT expMask;
    chanMaskT   expCtest;
    for (int i = 0; i < 10; i++) begin
      revDac[9 - i] = curDac[i];  // Chip takes the LSB first
    end
    for (int i = 0; i < 192; i++) begin
      expMask[i] = ((i / 3) == int'(curChan));
    end
    for (int i = 0; i < 64; i++) begin
      expCtest[i] = ctestInject && (i == int'(curChan));
    end
    checks++;
    if (dacCode !== revDac) begin
      errors++;
      $display("mismatch at %0t: dacCode %h, expected %h", $time, dacCode, revDac);
    end
    if (discriMask !== expMask || ctestChan !== expCtest) begin
      errors++;
      $display("mismatch at %0t: masks wrong for channel %0d", $time, curChan);
    end
  endtask

  task automatic stepCycle();
    @(negedge Clk);
    if (windowLeft > 0) begin
      if (trigger && trigCount != 16'hFFFF) begin
        trigCount = trigCount + 16'd1;
      end
      windowLeft = windowLeft - 1;
      if (windowLeft == 0) begin
        modelCounts.push_back(trigCount);
      end
    end
    if (prevRaz && !forceRaz) begin  // First sample two edges after the fall
      windowLeft = int'(TbCountWindow);
      trigCount  = '0;
    end
    prevRaz = forceRaz;
    if (usbWrite) begin
      checkWord(usbData);
    end
    if (scLoad) begin
      checkParams();
    end
  endtask

  task automatic runScan(input logic single, input logic inject, input chanT chan);
    int waited;
    buildStream(single, chan);
    @(posedge Clk);
    singleMode  <= single;
    ctestInject <= inject;
    singleChan  <= chan;
    testStart   <= 1'b1;
    stepCycle();
    @(posedge Clk);
    testStart <= 1'b0;
    waited = 0;
    do begin
      stepCycle();
      waited++;
    end while (!testDone && waited < RunTimeout);
    if (!testDone) begin
      errors++;
      timedOut = 1'b1;
      $display("Timed out at %0t waiting for testDone to rise", $time);
    end else begin
      if (expWords.size() != 0 || modelCounts.size() != 0) begin
        errors++;
        $display("testDone rose at %0t with %0d stream words still missing", $time,
                 expWords.size());
      end
      waited = 0;
      do begin
        stepCycle();
        waited++;
      end while (testDone && waited < RunTimeout);
      if (testDone) begin
        errors++;
        timedOut = 1'b1;
        $display("Timed out at %0t waiting for testDone to fall", $time);
      end
    end
  endtask

  initial begin
    void'($urandom(37));
    reset_n     = 1'b0;
    testStart   = 1'b0;
    singleMode  = 1'b0;
    singleChan  = '0;
    ctestInject = 1'b0;
    repeat (10) @(posedge Clk);
    reset_n <= 1'b1;
    stepCycle();
    checks++;
    if (scLoad !== 1'b0 || usbWrite !== 1'b0 || forceRaz !== 1'b0 || testDone !== 1'b0 ||
        dut0.fifoWrite !== 1'b0 || dut0.fifoRead !== 1'b0 || dut0.countStart !== 1'b0 ||
        dut0.countDone !== 1'b0 || discriMask !== '1) begin
      errors++;
      $display("mismatch at %0t: outputs not at their reset values", $time);
    end
    runScan(1'b1, 1'b1, chanT'($urandom_range(0, 63)));
    if (!timedOut) begin
      runScan(1'b1, 1'b0, chanT'($urandom_range(0, 63)));
    end
    if (!timedOut) begin
      runScan(1'b0, 1'b1, '0);  // All 64 channels
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
design/scurvePkg.sv
design/triggerCounter.sv
design/countFifo.sv
design/scurveControl.sv
design/scurveTop.sv
tests/scurveTop_properties.sv
tests/scurveTb.sv

//--- Makefile
# Verilator simulation of the S-curve scan subsystem

VERILATOR ?= verilator
TOP       ?= scurveTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Build, run and search the log for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
